//--- list.f
memStagePkg.sv
memExcChecker.sv
memAccessUnit.sv
dataMemory.sv
timerDevice.sv
excLogRegs.sv
memStage.sv
memStageChecker.sv
tb_memStage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_memStage
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "^Done: no errors$$" $(LOG); then echo "test passed"; \
	else echo "test failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_memStage.sv
`timescale 1ns/1ns

module tb_memStage import memStagePkg::*; ();

	logic                clk;
	logic                arstN;
	memReq               req;
	memResp              resp;
	logic [regAddrW-1:0] awaddr;
	logic                awvalid;
	logic                awready;
	logic [31:0]         wdata;
	logic [3:0]          wstrb;
	logic                wvalid;
	logic                wready;
	logic [1:0]          bresp;
	logic                bvalid;
	logic                bready;
	logic [regAddrW-1:0] araddr;
	logic                arvalid;
	logic                arready;
	logic [31:0]         rdata;
	logic [1:0]          rresp;
	logic                rvalid;
	logic                rready;
	logic                irq0;
	logic                irq1;

	// Expected values handed to the checker
	memResp      expResp;
	logic        expCheckData;
	logic [31:0] expRdata;
	int          errCount;
	int          pendingCount;

	// Model state
	logic [31:0] shadowMem [dmWords];
	logic [31:0] timerCtrl [2];
	logic [31:0] timerPreset [2];
	logic        devEnableSh;
	logic [4:0]  lastCause;
	logic [31:0] lastBadAddr;
	int          excSinceClear;
	int          timeoutCount;
	int          axiTimeout;
	integer      seed;
	logic [5:0]  opTable [9];

	memStage memStage_inst (.*);

	memStageChecker memStageChecker_inst (
		.clk(clk),
		.req(req),
		.resp(resp),
		.expResp(expResp),
		.expCheckData(expCheckData),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.expRdata(expRdata),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.irq0(irq0),
		.irq1(irq1),
		.errCount(errCount),
		.pendingCount(pendingCount)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic isLoadOp(input logic [5:0] op);
		return op inside {opLB, opLBU, opLH, opLHU, opLW};
	endfunction

	function automatic logic isStoreOp(input logic [5:0] op);
		return op inside {opSB, opSH, opSW};
	endfunction

	function automatic int opSize(input logic [5:0] op);
		if (op == opLW || op == opSW)
			return 4;
		if (op == opLH || op == opLHU || op == opSH)
			return 2;
		return 1;
	endfunction

	function automatic logic [31:0] fillWord(input logic [31:0] a);
		return (a * 32'h9E37_79B9) ^ 32'hC3A5_1E0F;
	endfunction

	// Timers are never started, so count stays equal to preset
	function automatic logic [31:0] readTimer(input logic [31:0] a);
		if (a[3:2] == 2'd0)
			return timerCtrl[a[4]];
		return timerPreset[a[4]];
	endfunction

	function automatic memResp refResp(input memReq r);
		memResp      e;
		logic [5:0]  op;
		logic [31:0] a;
		logic        load;
		logic        store;
		int          size;
		logic        inMem;
		logic        inDev;
		logic [31:0] word;
		logic [15:0] half;
		logic [7:0]  oneByte;
		logic        zext;
		e = '0;
		e.valid = 1'b1;
		op = r.instr[31:26];
		a = r.addr;
		load = isLoadOp(op);
		store = isStoreOp(op);
		size = opSize(op);
		zext = op == opLBU || op == opLHU;
		// Memory window starts at address zero
		inMem = a <= dmMax;
		if (load)
			inDev = devEnableSh &&
				((a >= dev0Min && a <= dev0Max) || (a >= dev1Min && a <= dev1Max));
		else
			inDev = devEnableSh &&
				((a >= dev0Min && a < dev0Max) || (a >= dev1Min && a < dev1Max));
		if (r.preExc)
		begin
			e.exc = 1'b1;
			e.excCode = r.preExcCode;
		end
		else if ((load || store) &&
			((a % size) != 0 || !(inMem || inDev) || (inDev && size != 4)))
		begin
			e.exc = 1'b1;
			e.excCode = store ? excAdES : excAdEL;
		end
		else if (load)
		begin
			word = inMem ? shadowMem[a[13:2]] : readTimer(a);
			half = a[1] ? word[31:16] : word[15:0];
			oneByte = word[8*a[1:0] +: 8];
			if (size == 4)
				e.loadData = word;
			else if (size == 2)
				e.loadData = zext ? {16'd0, half} : {{16{half[15]}}, half};
			else
				e.loadData = zext ? {24'd0, oneByte} : {{24{oneByte[7]}}, oneByte};
		end
		return e;
	endfunction

	// Apply a request's side effects to the model
	task automatic recordEffects(input memReq r, input memResp e);
		logic [11:0] idx;
		int          size;
		idx = r.addr[13:2];
		size = opSize(r.instr[31:26]);
		if (e.exc)
		begin
			excSinceClear++;
			lastCause = e.excCode;
			lastBadAddr = r.addr;
		end
		else if (isStoreOp(r.instr[31:26]))
		begin
			if (r.addr <= dmMax)
			begin
				if (size == 4)
					shadowMem[idx] = r.storeData;
				else if (size == 2)
					shadowMem[idx][16*r.addr[1] +: 16] = r.storeData[15:0];
				else
					shadowMem[idx][8*r.addr[1:0] +: 8] = r.storeData[7:0];
			end
			else if (r.addr[3:2] == 2'd0)
				timerCtrl[r.addr[4]] = r.storeData;
			else
				timerPreset[r.addr[4]] = r.storeData;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic sendReqWithExc(input logic [5:0] op, input logic [31:0] addr,
		input logic [31:0] data, input logic preExc, input logic [4:0] preCode);
		memReq  r;
		memResp e;
		r.valid = 1'b1;
		r.preExc = preExc;
		r.preExcCode = preCode;
		r.instr = {op, 5'd4, 5'd8, 16'h0010};
		r.addr = addr;
		r.storeData = data;
		e = refResp(r);
		@(posedge clk);
		req <= r;
		expResp <= e;
		expCheckData <= isLoadOp(op) && !e.exc;
		recordEffects(r, e);
	endtask

	task automatic sendReq(input logic [5:0] op, input logic [31:0] addr,
		input logic [31:0] data);
		sendReqWithExc(op, addr, data, 1'b0, 5'd0);
	endtask

	task automatic idle(input int cycles);
		repeat (cycles)
		begin
			@(posedge clk);
			req <= '0;
		end
	endtask

	task automatic sendRandomReq();
		logic [31:0] r;
		logic [31:0] sel;
		logic [31:0] addr;
		logic [31:0] data;
		r = $random(seed);
		sel = $random(seed);
		case (sel[2:0])
			3'd4:
				addr = 32'h0000_2FF8 + {28'd0, sel[31:28]};
			3'd5, 3'd6:
				addr = dev0Min + {27'd0, sel[31:27]};
			3'd7:
				addr = $random(seed);
			default:
				addr = {24'd0, sel[31:24]};
		endcase
		// Bias toward aligned accesses
		if (sel[8])
			addr[1:0] = 2'b00;
		data = $random(seed);
		// Keep timers stopped
		if (addr[31:8] == 24'h7F)
			data[0] = 1'b0;
		sendReqWithExc(opTable[r % 9], addr, data, r[12:9] == 4'd0, r[17:13]);
	endtask

	task automatic reportTimeout(input string what);
		$display("timeout while waiting for %s", what);
		timeoutCount++;
	endtask

	task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data);
		int waitCount;
		@(posedge clk);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wstrb <= 4'hF;
		wvalid <= 1'b1;
		bready <= 1'b1;
		waitCount = 0;
		@(negedge clk);
		while (!(awready && wready) && waitCount < axiTimeout)
		begin
			waitCount++;
			@(negedge clk);
		end
		if (!(awready && wready))
			reportTimeout("the write address and data handshake");
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		waitCount = 0;
		@(negedge clk);
		while (!bvalid && waitCount < axiTimeout)
		begin
			waitCount++;
			@(negedge clk);
		end
		if (!bvalid)
			reportTimeout("the write response");
		@(posedge clk);
		bready <= 1'b0;
		if (addr[3:2] == regCtrl)
			devEnableSh = data[0];
		if (addr[3:2] == regExcCount)
			excSinceClear = 0;
	endtask

	// Hold rready low for a number of cycles once rvalid is up
	task automatic axiRead(input logic [3:0] addr, input logic [31:0] expected,
		input int hold);
		int waitCount;
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		rready <= 1'b0;
		expRdata <= expected;
		waitCount = 0;
		@(negedge clk);
		while (!arready && waitCount < axiTimeout)
		begin
			waitCount++;
			@(negedge clk);
		end
		if (!arready)
			reportTimeout("the read address handshake");
		@(posedge clk);
		arvalid <= 1'b0;
		waitCount = 0;
		@(negedge clk);
		while (!rvalid && waitCount < axiTimeout)
		begin
			waitCount++;
			@(negedge clk);
		end
		if (!rvalid)
			reportTimeout("read data");
		repeat (hold)
			@(negedge clk);
		@(posedge clk);
		rready <= 1'b1;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		arstN = 1'b0;
		req = '0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		expResp = '0;
		expCheckData = 1'b0;
		expRdata = '0;
		for (int i = 0; i < dmWords; i++)
			shadowMem[i] = '0;
		timerCtrl = '{32'd0, 32'd0};
		timerPreset = '{32'd0, 32'd0};
		devEnableSh = 1'b1;
		lastCause = '0;
		lastBadAddr = '0;
		excSinceClear = 0;
		timeoutCount = 0;
		axiTimeout = 16;
		seed = 32'h84f8_fa74;
		opTable = '{opLB, opLBU, opLH, opLHU, opLW, opSB, opSH, opSW, 6'h0F};
		repeat (4)
			@(posedge clk);
		arstN <= 1'b1;

		// Preload both ends of the data memory
		for (int a = 0; a < 256; a += 4)
			sendReq(opSW, 32'(a), fillWord(32'(a)));
		for (int a = 32'h2F00; a < 32'h3000; a += 4)
			sendReq(opSW, 32'(a), fillWord(32'(a)));
		idle(2);

		// Sub-word stores and extended loads
		sendReq(opSB, 32'h11, 32'h0000_0080);
		sendReq(opLB, 32'h11, 32'h0);
		sendReq(opLBU, 32'h11, 32'h0);
		sendReq(opLW, 32'h10, 32'h0);
		sendReq(opSH, 32'h22, 32'h0000_8001);
		sendReq(opLH, 32'h22, 32'h0);
		sendReq(opLHU, 32'h22, 32'h0);
		sendReq(opLW, 32'h20, 32'h0);
		sendReq(opSH, 32'h24, 32'h0000_7FFE);
		sendReq(opLH, 32'h24, 32'h0);
		sendReq(opLB, 32'h27, 32'h0);
		sendReq(opSW, 32'h2FFC, 32'hDEAD_BEEF);
		sendReq(opLW, 32'h2FFC, 32'h0);
		sendReq(opLBU, 32'h2FFF, 32'h0);

		// Misaligned accesses leave memory unchanged
		sendReq(opSW, 32'h41, 32'h1111_2222);
		sendReq(opLW, 32'h40, 32'h0);
		sendReq(opSH, 32'h43, 32'h3333_4444);
		sendReq(opLH, 32'h45, 32'h0);
		sendReq(opLW, 32'h46, 32'h0);
		sendReq(opLH, 32'h42, 32'h0);

		// Range, device size and pass-through cases
		sendReq(opLW, 32'h3000, 32'h0);
		sendReq(opSB, 32'h3000, 32'h55);
		sendReq(opLW, 32'h7F0C, 32'h0);
		sendReq(opLB, 32'h7F04, 32'h0);
		sendReq(opSH, 32'h7F04, 32'h0);
		sendReq(opSW, 32'h7F08, 32'h0);
		sendReq(opSW, 32'h7F18, 32'h0);
		sendReq(6'h0F, 32'h41, 32'h0);
		sendReqWithExc(opLW, 32'h41, 32'h0, 1'b1, 5'd10);
		sendReqWithExc(opSW, 32'h3000, 32'h0, 1'b1, 5'd12);

		// Timer preset and count with ctrl cleared
		sendReq(opSW, 32'h7F04, 32'h1234_5678);
		sendReq(opLW, 32'h7F04, 32'h0);
		sendReq(opLW, 32'h7F08, 32'h0);
		sendReq(opLW, 32'h7F00, 32'h0);
		sendReq(opSW, 32'h7F14, 32'h00C0_FFEE);
		sendReq(opLW, 32'h7F14, 32'h0);
		sendReq(opLW, 32'h7F18, 32'h0);
		idle(2);

		// Exception log registers
		axiWrite({regExcCount, 2'b00}, 32'h0);
		sendReq(opLW, 32'h3000, 32'h0);
		sendReq(opSH, 32'h45, 32'h0);
		sendReq(opLW, 32'h8, 32'h0);
		sendReq(opLB, 32'h7F10, 32'h0);
		idle(2);
		axiRead({regCause, 2'b00}, {27'd0, lastCause}, 3);
		axiRead({regBadAddr, 2'b00}, lastBadAddr, 0);
		axiRead({regExcCount, 2'b00}, 32'(excSinceClear), 5);
		axiWrite({regExcCount, 2'b00}, 32'h0000_FFFF);
		axiRead({regExcCount, 2'b00}, 32'h0, 0);
		axiRead({regCtrl, 2'b00}, 32'h1, 0);

		// Device enable off, then back on
		axiWrite({regCtrl, 2'b00}, 32'h0);
		sendReq(opLW, 32'h7F04, 32'h0);
		sendReq(opSW, 32'h7F04, 32'h0000_0100);
		idle(2);
		axiRead({regCtrl, 2'b00}, 32'h0, 2);
		axiWrite({regCtrl, 2'b00}, 32'h1);
		sendReq(opLW, 32'h7F04, 32'h0);
		idle(2);

		for (int i = 0; i < 400; i++)
			sendRandomReq();
		idle(3);
		axiRead({regExcCount, 2'b00}, 32'(excSinceClear), 4);
		axiRead({regBadAddr, 2'b00}, lastBadAddr, 0);
		idle(3);

		@(posedge clk);
		if (pendingCount != 0)
			$display("%0d requests still wait for a response", pendingCount);
		$display("Error counts: checks %0d, timeouts %0d, lost responses %0d",
			errCount, timeoutCount, pendingCount);
		if (errCount == 0 && timeoutCount == 0 && pendingCount == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- memStageChecker.sv
`timescale 1ns/1ns

module memStageChecker import memStagePkg::*; (
	input  logic        clk,
	input  memReq       req,
	input  memResp      resp,
	input  memResp      expResp,
	input  logic        expCheckData,
	input  logic [31:0] rdata,
	input  logic [1:0]  rresp,
	input  logic        rvalid,
	input  logic        rready,
	input  logic [31:0] expRdata,
	input  logic [1:0]  bresp,
	input  logic        bvalid,
	input  logic        bready,
	input  logic        irq0,
	input  logic        irq1,
	output int          errCount,
	output int          pendingCount
);

	memResp      expQ[$];
	logic        checkQ[$];
	logic [31:0] addrQ[$];
	memResp      want;
	logic        checkData;
	logic [31:0] wantAddr;
	logic        stalled;
	logic [31:0] stalledData;

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		$display("mismatch %s: got %h, expected %h", name, got, expected);
		errCount++;
	endtask

	task automatic reportFailure(input string what);
		$display("%s", what);
		errCount++;
	endtask

	// Everything sampled mid-cycle on the falling edge
	initial
	begin
		errCount = 0;
		pendingCount = 0;
		stalled = 1'b0;
		stalledData = '0;
		forever
		begin
			@(negedge clk);

			// Request seen one cycle ago answers now
			if (expQ.size() != 0)
			begin
				want = expQ.pop_front();
				checkData = checkQ.pop_front();
				wantAddr = addrQ.pop_front();
				if (!resp.valid)
					reportFailure($sformatf("no response one cycle after request at %h",
						wantAddr));
				else
				begin
					if (resp.exc !== want.exc)
						reportMismatch($sformatf("resp.exc (addr %h)", wantAddr),
							{31'd0, resp.exc}, {31'd0, want.exc});
					if (resp.excCode !== want.excCode)
						reportMismatch($sformatf("resp.excCode (addr %h)", wantAddr),
							{27'd0, resp.excCode}, {27'd0, want.excCode});
					if (checkData && resp.loadData !== want.loadData)
						reportMismatch($sformatf("resp.loadData (addr %h)", wantAddr),
							resp.loadData, want.loadData);
				end
			end
			else if (resp.valid)
				reportFailure("response valid without a pending request");

			if (req.valid)
			begin
				expQ.push_back(expResp);
				checkQ.push_back(expCheckData);
				addrQ.push_back(req.addr);
			end

			// Timers never run, so neither interrupt may rise
			if (irq0 !== 1'b0)
				reportMismatch("irq0", {31'd0, irq0}, 32'd0);
			if (irq1 !== 1'b0)
				reportMismatch("irq1", {31'd0, irq1}, 32'd0);

			////////////////////////////////////////////////////////////////////
			// Register bus
			////////////////////////////////////////////////////////////////////

			if (stalled && (!rvalid || rdata !== stalledData))
				reportFailure("read data was not held while rready was low");
			stalled = rvalid && !rready;
			stalledData = rdata;
			if (rvalid && rready)
			begin
				if (rdata !== expRdata)
					reportMismatch("rdata", rdata, expRdata);
				if (rresp !== axiOkay)
					reportMismatch("rresp", {30'd0, rresp}, {30'd0, axiOkay});
			end
			if (bvalid && bready && bresp !== axiOkay)
				reportMismatch("bresp", {30'd0, bresp}, {30'd0, axiOkay});

			pendingCount = expQ.size();
		end
	end

endmodule

//--- memStage.sv
`timescale 1ns/1ns

module memStage import memStagePkg::*; (
	input  logic                clk,
	input  logic                arstN,
	input  memReq               req,
	output memResp              resp,
	input  logic [regAddrW-1:0] awaddr,
	input  logic                awvalid,
	output logic                awready,
	input  logic [31:0]         wdata,
	input  logic [3:0]          wstrb,
	input  logic                wvalid,
	output logic                wready,
	output logic [1:0]          bresp,
	output logic                bvalid,
	input  logic                bready,
	input  logic [regAddrW-1:0] araddr,
	input  logic                arvalid,
	output logic                arready,
	output logic [31:0]         rdata,
	output logic [1:0]          rresp,
	output logic                rvalid,
	input  logic                rready,
	output logic                irq0,
	output logic                irq1
);

	accessKind          kind;
	logic               exc;
	logic [4:0]         excCode;
	logic               devEnable;
	logic [dmAddrW-1:0] memAddr;
	logic [3:0]         memByteEn;
	logic [31:0]        memWdata;
	logic [31:0]        memRdata;
	logic [1:0]         devSel;
	logic [1:0]         devOffset;
	logic               devWe;
	logic [31:0]        devWdata;
	logic [31:0]        dev0Rdata;
	logic [31:0]        dev1Rdata;

	memExcChecker memExcChecker_inst (
		.req(req), .devEnable(devEnable), .kind(kind), .exc(exc), .excCode(excCode)
	);

	memAccessUnit memAccessUnit_inst (
		.clk(clk), .arstN(arstN), .req(req), .kind(kind), .exc(exc), .excCode(excCode),
		.memAddr(memAddr), .memByteEn(memByteEn), .memWdata(memWdata), .memRdata(memRdata),
		.devSel(devSel), .devOffset(devOffset), .devWe(devWe), .devWdata(devWdata),
		.dev0Rdata(dev0Rdata), .dev1Rdata(dev1Rdata), .resp(resp)
	);

	dataMemory dataMemory_inst (
		.clk(clk), .addr(memAddr), .byteEn(memByteEn), .wdata(memWdata), .rdata(memRdata)
	);

	// Two timers share offset, strobe and data
	timerDevice timer0_inst (
		.clk(clk), .arstN(arstN), .sel(devSel[0]), .offset(devOffset), .we(devWe),
		.wdata(devWdata), .rdata(dev0Rdata), .irq(irq0)
	);

	timerDevice timer1_inst (
		.clk(clk), .arstN(arstN), .sel(devSel[1]), .offset(devOffset), .we(devWe),
		.wdata(devWdata), .rdata(dev1Rdata), .irq(irq1)
	);

	excLogRegs excLogRegs_inst (
		.clk(clk), .arstN(arstN),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.excEvent(req.valid && exc), .excCode(excCode), .excAddr(req.addr),
		.devEnable(devEnable)
	);

endmodule

//--- excLogRegs.sv
`timescale 1ns/1ns

module excLogRegs import memStagePkg::*; (
	input  logic                clk,
	input  logic                arstN,
	input  logic [regAddrW-1:0] awaddr,
	input  logic                awvalid,
	output logic                awready,
	input  logic [31:0]         wdata,
	input  logic [3:0]          wstrb,
	input  logic                wvalid,
	output logic                wready,
	output logic [1:0]          bresp,
	output logic                bvalid,
	input  logic                bready,
	input  logic [regAddrW-1:0] araddr,
	input  logic                arvalid,
	output logic                arready,
	output logic [31:0]         rdata,
	output logic [1:0]          rresp,
	output logic                rvalid,
	input  logic                rready,
	input  logic                excEvent,
	input  logic [4:0]          excCode,
	input  logic [31:0]         excAddr,
	output logic                devEnable
);

	logic        wrAccept;
	logic        wrFire;
	logic        rdFire;
	logic        countClr;
	logic [4:0]  cause;
	logic [31:0] badAddr;
	logic [31:0] excCount;

	assign wrFire = wrAccept && awvalid && wvalid;
	assign rdFire = arready && arvalid;
	assign countClr = wrFire && awaddr[3:2] == regExcCount;

	assign awready = wrAccept;
	assign wready = wrAccept;
	assign bresp = axiOkay;
	assign rresp = axiOkay;

	////////////////////////////////////////////////////////////////////////////
	// Handshake
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN)
		if (!arstN)
		begin
			wrAccept <= 1'b0;
			bvalid <= 1'b0;
			arready <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			// One-cycle ready once address and data are both present
			wrAccept <= awvalid && wvalid && !wrAccept && !bvalid;
			if (wrFire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			arready <= arvalid && !arready && !rvalid;
			if (rdFire)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end

	always_ff @(posedge clk)
		if (rdFire)
			case (araddr[3:2])
				regCtrl:    rdata <= {31'd0, devEnable};
				regCause:   rdata <= {27'd0, cause};
				regBadAddr: rdata <= badAddr;
				default:    rdata <= excCount;
			endcase

	////////////////////////////////////////////////////////////////////////////
	// Registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN)
		if (!arstN)
		begin
			devEnable <= 1'b1;
			cause <= '0;
			badAddr <= '0;
			excCount <= '0;
		end
		else
		begin
			if (wrFire && awaddr[3:2] == regCtrl && wstrb[0])
				devEnable <= wdata[0];
			if (excEvent)
			begin
				cause <= excCode;
				badAddr <= excAddr;
			end
			// A clear still counts an exception in the same cycle
			if (countClr)
				excCount <= {31'd0, excEvent};
			else if (excEvent && excCount != '1)
				excCount <= excCount + 1'b1;
		end

endmodule

//--- timerDevice.sv
`timescale 1ns/1ns

module timerDevice import memStagePkg::*; (
	input  logic        clk,
	input  logic        arstN,
	input  logic        sel,
	input  logic [1:0]  offset,
	input  logic        we,
	input  logic [31:0] wdata,
	output logic [31:0] rdata,
	output logic        irq
);

	logic [31:0] ctrl;
	logic [31:0] preset;
	logic [31:0] count;
	logic        wrEn;

	assign wrEn = sel && we;

	always_ff @(posedge clk or negedge arstN)
		if (!arstN)
		begin
			ctrl <= '0;
			preset <= '0;
			count <= '0;
		end
		else
		begin
			if (wrEn && offset == tmrCtrl)
				ctrl <= wdata;
			// Preset reloads the counter
			if (wrEn && offset == tmrPreset)
			begin
				preset <= wdata;
				count <= wdata;
			end
			else if (ctrl[0] && count != '0)
				count <= count - 1'b1;
		end

	always_ff @(posedge clk)
		if (sel)
			case (offset)
				tmrCtrl:   rdata <= ctrl;
				tmrPreset: rdata <= preset;
				tmrCount:  rdata <= count;
				default:   rdata <= '0;
			endcase

	// Held while running and expired
	assign irq = ctrl[0] && count == '0;

endmodule

//--- dataMemory.sv
`timescale 1ns/1ns

module dataMemory import memStagePkg::*; (
	input  logic               clk,
	input  logic [dmAddrW-1:0] addr,
	input  logic [3:0]         byteEn,
	input  logic [31:0]        wdata,
	output logic [31:0]        rdata
);

	logic [31:0] mem [dmWords];

	// Byte lanes written independently
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 4; i++)
		begin
			if (byteEn[i])
				mem[addr][8*i +: 8] <= wdata[8*i +: 8];
		end
	end

	// Registered read returns old data on a same-cycle write
	always_ff @(posedge clk)
		rdata <= mem[addr];

endmodule

//--- memAccessUnit.sv
`timescale 1ns/1ns

module memAccessUnit import memStagePkg::*; (
	input  logic               clk,
	input  logic               arstN,
	input  memReq              req,
	input  accessKind          kind,
	input  logic               exc,
	input  logic [4:0]         excCode,
	output logic [dmAddrW-1:0] memAddr,
	output logic [3:0]         memByteEn,
	output logic [31:0]        memWdata,
	input  logic [31:0]        memRdata,
	output logic [1:0]         devSel,
	output logic [1:0]         devOffset,
	output logic               devWe,
	output logic [31:0]        devWdata,
	input  logic [31:0]        dev0Rdata,
	input  logic [31:0]        dev1Rdata,
	output memResp             resp
);

	logic       active;
	logic       inDev0;
	logic       inDev1;
	logic [1:0] lane;
	logic [1:0] target;
	logic [3:0] laneMask;
	logic       zeroExt;
	dataWord    storeWord;
	dataWord    loadWord;
	logic [15:0] loadHalf;
	logic [7:0]  loadByte;
	logic [31:0] loadData;

	// Captured for the data phase
	logic       validQ;
	logic       excQ;
	logic [4:0] excCodeQ;
	accessKind  kindQ;
	logic [1:0] laneQ;
	logic [1:0] targetQ;
	logic       zeroExtQ;

	////////////////////////////////////////////////////////////////////////////
	// Request phase
	////////////////////////////////////////////////////////////////////////////

	assign active = req.valid && !exc && (kind.isLoad || kind.isStore);
	assign lane = req.addr[1:0];
	assign inDev0 = req.addr >= dev0Min && req.addr <= dev0Max;
	assign inDev1 = req.addr >= dev1Min && req.addr <= dev1Max;
	assign target = inDev0 ? tgtDev0 : inDev1 ? tgtDev1 : tgtMem;
	assign zeroExt = req.instr[31:26] == opLBU || req.instr[31:26] == opLHU;

	assign laneMask = kind.word ? 4'b1111 :
		kind.half ? (lane[1] ? 4'b1100 : 4'b0011) :
		4'b0001 << lane;

	// Move store data into the addressed lane
	always_comb
	begin
		storeWord = '0;
		if (kind.word)
			storeWord = req.storeData;
		else if (kind.half)
			storeWord.halves[lane[1]] = req.storeData[15:0];
		else
			storeWord.bytes[lane] = req.storeData[7:0];
	end

	assign memAddr = req.addr[dmAddrW+1:2];
	assign memWdata = storeWord;
	assign memByteEn = (active && kind.isStore && target == tgtMem) ? laneMask : 4'b0000;

	assign devSel = {active && inDev1, active && inDev0};
	assign devOffset = req.addr[3:2];
	assign devWe = active && kind.isStore;
	// Devices take word accesses only
	assign devWdata = req.storeData;

	always_ff @(posedge clk or negedge arstN)
		if (!arstN)
			validQ <= 1'b0;
		else
			validQ <= req.valid;

	always_ff @(posedge clk)
	begin
		excQ <= exc;
		excCodeQ <= excCode;
		kindQ <= kind;
		laneQ <= lane;
		targetQ <= target;
		zeroExtQ <= zeroExt;
	end

	////////////////////////////////////////////////////////////////////////////
	// Data phase
	////////////////////////////////////////////////////////////////////////////

	assign loadWord = (targetQ == tgtDev0) ? dev0Rdata :
		(targetQ == tgtDev1) ? dev1Rdata : memRdata;
	assign loadHalf = loadWord.halves[laneQ[1]];
	assign loadByte = loadWord.bytes[laneQ];

	always_comb
	begin
		if (excQ || !kindQ.isLoad)
			loadData = '0;
		else if (kindQ.word)
			loadData = loadWord;
		else if (kindQ.half)
			loadData = {{16{!zeroExtQ && loadHalf[15]}}, loadHalf};
		else
			loadData = {{24{!zeroExtQ && loadByte[7]}}, loadByte};
	end

	assign resp = '{valid: validQ, exc: excQ, excCode: excCodeQ, loadData: loadData};

endmodule

//--- memExcChecker.sv
`timescale 1ns/1ns

module memExcChecker import memStagePkg::*; (
	input  memReq      req,
	input  logic       devEnable,
	output accessKind  kind,
	output logic       exc,
	output logic [4:0] excCode
);

	logic misaligned;
	logic inDm;
	logic inDevRead;
	logic inDevWrite;
	logic outOfRange;
	logic nonWordDev;
	logic addrErr;

	// Opcode decode into direction and size
	always_comb
	begin
		kind = '0;
		case (req.instr[31:26])
			opLB, opLBU:
				kind.isLoad = 1'b1;
			opLH, opLHU:
			begin
				kind.isLoad = 1'b1;
				kind.half = 1'b1;
			end
			opLW:
			begin
				kind.isLoad = 1'b1;
				kind.word = 1'b1;
			end
			opSB:
				kind.isStore = 1'b1;
			opSH:
			begin
				kind.isStore = 1'b1;
				kind.half = 1'b1;
			end
			opSW:
			begin
				kind.isStore = 1'b1;
				kind.word = 1'b1;
			end
			default:
				kind = '0;
		endcase
	end

	assign misaligned = (kind.half && req.addr[0]) || (kind.word && req.addr[1:0] != 2'd0);

	assign inDm = req.addr >= dmMin && req.addr <= dmMax;

	// Devices only decode while enabled from the register block
	assign inDevRead = devEnable &&
		((req.addr >= dev0Min && req.addr <= dev0Max) ||
		 (req.addr >= dev1Min && req.addr <= dev1Max));
	assign inDevWrite = devEnable &&
		((req.addr >= dev0Min && req.addr < dev0Max) ||
		 (req.addr >= dev1Min && req.addr < dev1Max));

	assign outOfRange = (kind.isLoad && !(inDm || inDevRead)) ||
		(kind.isStore && !(inDm || inDevWrite));
	assign nonWordDev = !kind.word &&
		((kind.isLoad && inDevRead) || (kind.isStore && inDevWrite));

	assign addrErr = misaligned || outOfRange || nonWordDev;

	// Earlier exception wins over any address error
	assign exc = req.preExc || addrErr;
	assign excCode = req.preExc ? req.preExcCode :
		!addrErr ? 5'd0 :
		kind.isStore ? excAdES : excAdEL;

endmodule

//--- memStagePkg.sv
package memStagePkg;

	////////////////////////////////////////////////////////////////////////////
	// Opcodes and exception codes
	////////////////////////////////////////////////////////////////////////////

	localparam logic [5:0] opLB  = 6'h20;
	localparam logic [5:0] opLH  = 6'h21;
	localparam logic [5:0] opLW  = 6'h23;
	localparam logic [5:0] opLBU = 6'h24;
	localparam logic [5:0] opLHU = 6'h25;
	localparam logic [5:0] opSB  = 6'h28;
	localparam logic [5:0] opSH  = 6'h29;
	localparam logic [5:0] opSW  = 6'h2B;

	localparam logic [4:0] excAdEL = 5'd4;
	localparam logic [4:0] excAdES = 5'd5;

	////////////////////////////////////////////////////////////////////////////
	// Address map
	////////////////////////////////////////////////////////////////////////////

	localparam logic [31:0] dmMin   = 32'h0000_0000;
	localparam logic [31:0] dmMax   = 32'h0000_2FFF;
	// Top word of each device window is the read-only count
	localparam logic [31:0] dev0Min = 32'h0000_7F00;
	localparam logic [31:0] dev0Max = 32'h0000_7F08;
	localparam logic [31:0] dev1Min = 32'h0000_7F10;
	localparam logic [31:0] dev1Max = 32'h0000_7F18;

	// 3K words of data memory
	localparam int dmWords = 3072;
	localparam int dmAddrW = 12;

	// Access targets
	localparam logic [1:0] tgtMem  = 2'd0;
	localparam logic [1:0] tgtDev0 = 2'd1;
	localparam logic [1:0] tgtDev1 = 2'd2;

	// Timer word offsets
	localparam logic [1:0] tmrCtrl   = 2'd0;
	localparam logic [1:0] tmrPreset = 2'd1;
	localparam logic [1:0] tmrCount  = 2'd2;

	// Register block word offsets
	localparam int regAddrW = 4;
	localparam logic [1:0] regCtrl     = 2'd0;
	localparam logic [1:0] regCause    = 2'd1;
	localparam logic [1:0] regBadAddr  = 2'd2;
	localparam logic [1:0] regExcCount = 2'd3;
	localparam logic [1:0] axiOkay     = 2'b00;

	////////////////////////////////////////////////////////////////////////////
	// Shared types
	////////////////////////////////////////////////////////////////////////////

	typedef union packed {
		logic [3:0][7:0]  bytes;
		logic [1:0][15:0] halves;
	} dataWord;

	typedef struct packed {
		logic        valid;
		logic        preExc;
		logic [4:0]  preExcCode;
		logic [31:0] instr;
		logic [31:0] addr;
		logic [31:0] storeData;
	} memReq;

	typedef struct packed {
		logic        valid;
		logic        exc;
		logic [4:0]  excCode;
		logic [31:0] loadData;
	} memResp;

	typedef struct packed {
		logic isLoad;
		logic isStore;
		logic half;
		logic word;
	} accessKind;

endpackage
